// ==== hdl/spi_sram_ctrl.sv ====
`timescale 1ns/1ps

module spi_sram_ctrl #(
    parameter int FIFO_DEPTH = sram_pkg::DEF_FIFO_DEPTH,
    parameter int CLK_DIV    = sram_pkg::DEF_CLK_DIV
) (
    input  logic                clk,
    input  logic                rst_n,
    input  sram_pkg::word_t     wr_data,
    input  logic                wr_valid,
    output logic                wr_credit,
    input  sram_pkg::sram_cmd_t cmd,
    input  logic                cmd_valid,
    output logic                done,
    output sram_pkg::word_t     rd_data,
    output logic                rd_empty,
    input  logic                rd_pop,
    output logic                cs,
    output logic                sck,
    output logic                mosi,
    input  logic                miso
);

    localparam int SRAM_ADDR_BYTES = 2;         // 64 KB part.

    sram_pkg::word_t fifo_data;
    logic            fifo_empty;
    logic            fifo_pop;
    sram_pkg::word_t rd_word;
    logic            rd_push;

    ////////////////////////////////////////////////////////////
    // Write path, host to engine
    ////////////////////////////////////////////////////////////

    word_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_wr_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (wr_valid),
        .push_data (wr_data),
        .pop       (fifo_pop),
        .pop_data  (fifo_data),
        .empty     (fifo_empty),
        .full      (),
        .credit    (wr_credit)
    );

    spi_sram_engine #(
        .CLK_DIV    (CLK_DIV),
        .ADDR_BYTES (SRAM_ADDR_BYTES)
    ) i_engine (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd        (cmd),
        .cmd_valid  (cmd_valid),
        .done       (done),
        .fifo_data  (fifo_data),
        .fifo_empty (fifo_empty),
        .fifo_pop   (fifo_pop),
        .rd_push    (rd_push),
        .rd_word    (rd_word),
        .cs         (cs),
        .sck        (sck),
        .mosi       (mosi),
        .miso       (miso)
    );

    ////////////////////////////////////////////////////////////
    // Read path, engine to host
    ////////////////////////////////////////////////////////////

    word_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_rd_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (rd_push),
        .push_data (rd_word),
        .pop       (rd_pop),
        .pop_data  (rd_data),
        .empty     (rd_empty),
        .full      (),
        .credit    ()
    );

endmodule

// ==== hdl/spi_sram_engine.sv ====
`timescale 1ns/1ps

module spi_sram_engine #(
    parameter int CLK_DIV    = 2,
    parameter int ADDR_BYTES = 2
) (
    input  logic                clk,
    input  logic                rst_n,
    input  sram_pkg::sram_cmd_t cmd,
    input  logic                cmd_valid,
    output logic                done,
    input  sram_pkg::word_t     fifo_data,
    input  logic                fifo_empty,
    output logic                fifo_pop,
    output logic                rd_push,
    output sram_pkg::word_t     rd_word,
    output logic                cs,
    output logic                sck,
    output logic                mosi,
    input  logic                miso
);

    localparam int W      = sram_pkg::WORD_BITS;
    localparam int BIT_W  = $clog2(W);
    localparam int DIV_W  = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;
    localparam int ADDR_W = 8 * ADDR_BYTES;

    typedef enum logic [2:0] {
        S_IDLE,
        S_OPCODE,
        S_ADDR,
        S_WDATA,
        S_RDATA,
        S_FINISH
    } state_t;

    state_t              state;
    sram_pkg::sram_cmd_t cmd_q;
    logic [DIV_W-1:0]    div_cnt;
    logic [BIT_W-1:0]    bit_cnt;               // Bits left in this field, minus one.
    logic [5:0]          wcnt;                  // Words left, current one included.
    logic                sck_q;
    logic                cs_q;
    logic                done_q;
    logic                rd_push_q;
    sram_pkg::word_t     sh;
    sram_pkg::word_t     wbuf;
    sram_pkg::word_t     rd_sr;
    logic [7:0]          opcode;
    logic                accept;
    logic                shifting;
    logic                half_end;
    logic                rise;
    logic                fall;
    logic                last_bit;
    logic                is_wr;
    logic                want_pop;

    ////////////////////////////////////////////////////////////
    // Bit timing
    ////////////////////////////////////////////////////////////

    assign accept   = cmd_valid && done_q;
    assign shifting = (state == S_OPCODE) || (state == S_ADDR) ||
                      (state == S_WDATA) || (state == S_RDATA);
    assign half_end = shifting && (div_cnt == DIV_W'(CLK_DIV - 1));
    assign rise     = half_end && !sck_q;       // miso sampled here.
    assign fall     = half_end && sck_q;        // End of one bit.
    assign last_bit = fall && (bit_cnt == '0);
    assign is_wr    = (cmd_q.op == sram_pkg::CMD_WRITE);
    assign opcode   = (cmd.op == sram_pkg::CMD_WRITE) ? sram_pkg::OP_WRITE : sram_pkg::OP_READ;

    // Next write word is fetched as the previous one starts shifting.
    always_comb begin
        want_pop = 1'b0;
        if (last_bit && is_wr) begin
            case (state)
                S_OPCODE: want_pop = 1'b1;
                S_ADDR:   want_pop = (cmd_q.count > 6'd1);
                S_WDATA:  want_pop = (wcnt > 6'd2);
                default:  want_pop = 1'b0;
            endcase
        end
    end

    assign fifo_pop = want_pop && !fifo_empty;

    ////////////////////////////////////////////////////////////
    // Control FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= S_IDLE;
            div_cnt   <= '0;
            bit_cnt   <= '0;
            wcnt      <= '0;
            sck_q     <= 1'b0;
            cs_q      <= 1'b1;
            done_q    <= 1'b1;
            rd_push_q <= 1'b0;
        end else begin
            rd_push_q <= rise && (state == S_RDATA) && (bit_cnt == '0);
            if (half_end) begin
                div_cnt <= '0;
                sck_q   <= ~sck_q;
            end else if (shifting) begin
                div_cnt <= div_cnt + 1'b1;
            end
            case (state)
                S_IDLE: begin
                    if (accept) begin
                        state   <= S_OPCODE;
                        done_q  <= 1'b0;
                        cs_q    <= 1'b0;
                        bit_cnt <= BIT_W'(7);
                    end
                end
                S_FINISH: begin
                    state  <= S_IDLE;
                    done_q <= 1'b1;                 // One cycle after cs rises.
                end
                default: begin
                    if (fall && bit_cnt != '0) begin
                        bit_cnt <= bit_cnt - 1'b1;
                    end else if (last_bit) begin
                        case (state)
                            S_OPCODE: begin
                                state   <= S_ADDR;
                                bit_cnt <= BIT_W'(ADDR_W - 1);
                            end
                            S_ADDR: begin
                                if (is_wr) begin
                                    state <= S_WDATA;
                                end else begin
                                    state <= S_RDATA;
                                end
                                bit_cnt <= BIT_W'(W - 1);
                                wcnt    <= cmd_q.count;
                            end
                            default: begin
                                if (wcnt > 6'd1) begin
                                    wcnt    <= wcnt - 1'b1;
                                    bit_cnt <= BIT_W'(W - 1);
                                end else begin
                                    state <= S_FINISH;
                                    cs_q  <= 1'b1;
                                end
                            end
                        endcase
                    end
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Shift and data registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (accept) begin
            cmd_q <= cmd;
            sh    <= sram_pkg::word_t'(opcode) << (W - 8);
        end else if (fall) begin
            if (bit_cnt != '0) begin
                sh <= sh << 1;
            end else if (state == S_OPCODE) begin
                sh <= sram_pkg::word_t'(cmd_q.addr) << (W - ADDR_W);
            end else if (state == S_ADDR && is_wr) begin
                sh <= wbuf;
            end else if (state == S_WDATA && wcnt > 6'd1) begin
                sh <= wbuf;
            end else begin
                sh <= '0;                       // Idle mosi during reads.
            end
        end
        if (fifo_pop) begin
            wbuf <= fifo_data;
        end
        if (rise && state == S_RDATA) begin
            rd_sr <= {rd_sr[W-2:0], miso};      // First byte lands in 31:24.
        end
    end

    assign done    = done_q;
    assign cs      = cs_q;
    assign sck     = sck_q;
    assign mosi    = sh[W-1] & ~cs_q;
    assign rd_push = rd_push_q;
    assign rd_word = rd_sr;

endmodule

// ==== hdl/sram_pkg.sv ====
package sram_pkg;

    ////////////////////////////////////////////////////////////
    // Sizes and defaults
    ////////////////////////////////////////////////////////////

    parameter int WORD_BITS = 32;

    parameter int DEF_FIFO_DEPTH = 32;          // Words per FIFO.
    parameter int DEF_CLK_DIV    = 2;           // Half period of sck in clk cycles.

    typedef logic [WORD_BITS-1:0] word_t;

    ////////////////////////////////////////////////////////////
    // SPI opcodes, 23LC-class part
    ////////////////////////////////////////////////////////////

    parameter logic [7:0] OP_READ  = 8'h03;
    parameter logic [7:0] OP_WRITE = 8'h02;

    ////////////////////////////////////////////////////////////
    // Host command
    ////////////////////////////////////////////////////////////

    typedef enum logic {
        CMD_READ  = 1'b0,
        CMD_WRITE = 1'b1
    } sram_op_t;

    // One command as the host hands it over, 27 bits.
    typedef struct packed {
        sram_op_t    op;                        // Direction.
        logic [15:0] addr;                      // First byte address.
        logic [5:0]  count;                     // Words, 1 to 32.
        logic [3:0]  spare;                     // Reserved, keep zero.
    } sram_cmd_t;

endpackage

// ==== hdl/word_fifo.sv ====
`timescale 1ns/1ps

module word_fifo #(
    parameter int FIFO_DEPTH = 32
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            push,
    input  sram_pkg::word_t push_data,
    input  logic            pop,
    output sram_pkg::word_t pop_data,
    output logic            empty,
    output logic            full,
    output logic            credit
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    sram_pkg::word_t  mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    // Wraps for depths that are not a power of two.
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign empty    = (count == '0);
    assign full     = (count == CNT_W'(FIFO_DEPTH));
    assign do_pop   = pop && !empty;
    assign do_push  = push && (!full || do_pop);   // A slot frees this cycle.
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            credit <= 1'b0;
        end else begin
            credit <= do_pop;                   // One slot back to the host.
            if (do_push) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the SPI SRAM controller testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing -f sources.f --top-module tb_spi_sram -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "\*\* FAIL \*\*" sim.log; then
    exit 1
fi
grep -q "\*\* PASS \*\*" sim.log

// ==== sim/spi_sram_properties.sv ====
`timescale 1ns/1ps

module spi_sram_properties (
    input logic                clk,
    input logic                rst_n,
    input logic                cs,
    input logic                sck,
    input logic                done,
    input logic                wr_credit,
    input logic                wr_valid,
    input logic                fifo_pop,
    input sram_pkg::sram_cmd_t cmd,
    input logic                cmd_valid
);

    logic [6:0] wr_words;                       // Words held in the write FIFO.

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_words <= '0;
        end else begin
            wr_words <= wr_words + 7'(wr_valid) - 7'(fifo_pop);
        end
    end

    sck_idle_low: assert property (@(posedge clk) disable iff (!rst_n)
        cs |-> !sck) else $error("sck toggled while cs was high");

    // Slots are only freed by the engine during a transfer.
    credit_while_idle: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> !wr_credit) else $error("credit while no transfer was running");

    write_has_data: assert property (@(posedge clk) disable iff (!rst_n)
        (cmd_valid && done && cmd.op == sram_pkg::CMD_WRITE) |->
        (wr_words >= 7'(cmd.count))) else $error("write issued before its data");

endmodule

bind spi_sram_ctrl spi_sram_properties i_props (
    .clk       (clk),
    .rst_n     (rst_n),
    .cs        (cs),
    .sck       (sck),
    .done      (done),
    .wr_credit (wr_credit),
    .wr_valid  (wr_valid),
    .fifo_pop  (fifo_pop),
    .cmd       (cmd),
    .cmd_valid (cmd_valid)
);

// ==== sim/spi_sram_stimulus.txt ====
# op addr(hex) count(dec) words(hex); W writes the words, R and B expect them
# B reads while a second command is offered during the transfer
W 0100 1 a1b2c3d4
R 0100 1 a1b2c3d4
W 1000 32
f00d0000 f00d0101 f00d0202 f00d0303 f00d0404 f00d0505 f00d0606 f00d0707
f00d0808 f00d0909 f00d0a0a f00d0b0b f00d0c0c f00d0d0d f00d0e0e f00d0f0f
f00d1010 f00d1111 f00d1212 f00d1313 f00d1414 f00d1515 f00d1616 f00d1717
f00d1818 f00d1919 f00d1a1a f00d1b1b f00d1c1c f00d1d1d f00d1e1e f00d1f1f
R 1000 16
f00d0000 f00d0101 f00d0202 f00d0303 f00d0404 f00d0505 f00d0606 f00d0707
f00d0808 f00d0909 f00d0a0a f00d0b0b f00d0c0c f00d0d0d f00d0e0e f00d0f0f
R 1040 16
f00d1010 f00d1111 f00d1212 f00d1313 f00d1414 f00d1515 f00d1616 f00d1717
f00d1818 f00d1919 f00d1a1a f00d1b1b f00d1c1c f00d1d1d f00d1e1e f00d1f1f
W 2000 2 11111111 22222222
W 2004 2 33333333 44444444
R 2000 3 11111111 33333333 44444444
W 2002 1 55667788
R 2000 2 11115566 77883333
W 3000 1 deadbeef
R 0100 1 a1b2c3d4
B 1000 2 f00d0000 f00d0101
R 3000 1 deadbeef

// ==== sim/sram_model.sv ====
`timescale 1ns/1ps

module sram_model (
    input  logic cs,
    input  logic sck,
    input  logic mosi,
    output logic miso
);

    logic [7:0]  mem [65536];
    logic [7:0]  opcode;
    logic [15:0] addr;
    logic [7:0]  wbyte;
    int          cnt;                           // Bits received since cs fell.

    initial begin
        for (int i = 0; i < 65536; i++) begin
            mem[i] = 8'(i) ^ 8'(i >> 8);        // Both address bytes matter.
        end
    end

    ////////////////////////////////////////////////////////////
    // Command and write data, sampled on rising sck
    ////////////////////////////////////////////////////////////

    always @(posedge sck or posedge cs) begin
        logic [15:0] off;
        if (cs) begin
            cnt = 0;
        end else begin
            off = 16'((cnt - 24) / 8);
            if (cnt < 8) begin
                opcode = {opcode[6:0], mosi};
            end else if (cnt < 24) begin
                addr = {addr[14:0], mosi};
            end else if (opcode == sram_pkg::OP_WRITE) begin
                wbyte = {wbyte[6:0], mosi};
                if ((cnt - 24) % 8 == 7) begin
                    mem[addr + off] = wbyte;    // Auto-incrementing address.
                end
            end
            cnt = cnt + 1;
        end
    end

    // Read data goes out MSB first on falling sck.
    always @(negedge sck or posedge cs) begin
        logic [15:0] off;
        if (cs) begin
            miso = 1'b0;
        end else if (cnt >= 24 && opcode == sram_pkg::OP_READ) begin
            off  = 16'((cnt - 24) / 8);
            miso = mem[addr + off][7 - ((cnt - 24) % 8)];
        end
    end

endmodule

// ==== sim/tb_spi_sram.sv ====
`timescale 1ns/1ps

module tb_spi_sram;

    localparam int DEPTH   = sram_pkg::DEF_FIFO_DEPTH;
    localparam int TIMEOUT = 20000;             // clk cycles per wait.

    logic                clk;
    logic                rst_n;
    sram_pkg::word_t     wr_data;
    logic                wr_valid;
    logic                wr_credit;
    sram_pkg::sram_cmd_t cmd;
    logic                cmd_valid;
    logic                done;
    sram_pkg::word_t     rd_data;
    logic                rd_empty;
    logic                rd_pop;
    logic                cs;
    logic                sck;
    logic                mosi;
    logic                miso;

    int errors     = 0;
    int checks     = 0;
    int push_cnt   = 0;
    int credit_cnt = 0;

    spi_sram_ctrl #(
        .FIFO_DEPTH (DEPTH),
        .CLK_DIV    (sram_pkg::DEF_CLK_DIV)
    ) i_spi_sram_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_data   (wr_data),
        .wr_valid  (wr_valid),
        .wr_credit (wr_credit),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .done      (done),
        .rd_data   (rd_data),
        .rd_empty  (rd_empty),
        .rd_pop    (rd_pop),
        .cs        (cs),
        .sck       (sck),
        .mosi      (mosi),
        .miso      (miso)
    );

    sram_model i_sram_model (
        .cs   (cs),
        .sck  (sck),
        .mosi (mosi),
        .miso (miso)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        if (rst_n && wr_credit) begin
            credit_cnt <= credit_cnt + 1;       // One slot back per cycle.
        end
    end

    function automatic int credits_left();
        return DEPTH - push_cnt + credit_cnt;
    endfunction

    ////////////////////////////////////////////////////////////
    // Checks and waits
    ////////////////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("MISMATCH %s expected %08h actual %08h", name, exp, act);
        end
    endtask

    task automatic abort_on_timeout(input string what);
        errors++;
        $display("ERROR: timed out waiting for %s", what);
        $display("checks %0d, errors %0d", checks, errors);
        $display("** FAIL **");
        $finish;
    endtask

    task automatic wait_for_done(input logic level, input string what);
        int n;
        n = 0;
        @(negedge clk);
        while (done !== level) begin
            if (n == TIMEOUT) abort_on_timeout(what);
            @(negedge clk);
            n++;
        end
    endtask

    task automatic wait_for_data(input string what);
        int n;
        n = 0;
        @(negedge clk);
        while (rd_empty !== 1'b0) begin
            if (n == TIMEOUT) abort_on_timeout(what);
            @(negedge clk);
            n++;
        end
    endtask

    task automatic wait_for_credit();
        int n;
        n = 0;
        while (credits_left() <= 0) begin
            if (n == TIMEOUT) abort_on_timeout("a write credit");
            @(negedge clk);
            n++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Host operations
    ////////////////////////////////////////////////////////////

    task automatic issue_cmd(input sram_pkg::sram_op_t op, input logic [15:0] addr,
                             input int cnt);
        @(posedge clk);
        cmd       <= '{op: op, addr: addr, count: 6'(cnt), spare: 4'd0};
        cmd_valid <= 1'b1;
        @(posedge clk);
        cmd_valid <= 1'b0;
        wait_for_done(1'b0, "done to fall");
    endtask

    task automatic run_write(input string name, input logic [15:0] addr,
                             input logic [31:0] words[$]);
        int base;
        base = credit_cnt;
        foreach (words[i]) begin
            wait_for_credit();
            @(posedge clk);
            wr_data  <= words[i];
            wr_valid <= 1'b1;
            push_cnt++;
            @(posedge clk);
            wr_valid <= 1'b0;
        end
        issue_cmd(sram_pkg::CMD_WRITE, addr, words.size());
        wait_for_done(1'b1, "write to finish");
        check_value({name, " credits"}, 32'(words.size()), 32'(credit_cnt - base));
        check_value({name, " credit total"}, 32'(DEPTH), 32'(credits_left()));
    endtask

    task automatic run_read(input string name, input logic [15:0] addr,
                            input logic [31:0] exp[$], input bit busy_cmd);
        issue_cmd(sram_pkg::CMD_READ, addr, exp.size());
        if (busy_cmd) begin
            repeat (40) @(posedge clk);
            cmd       <= '{op: sram_pkg::CMD_READ, addr: 16'hffff, count: 6'd5, spare: 4'd0};
            cmd_valid <= 1'b1;                  // Must be ignored.
            @(posedge clk);
            cmd_valid <= 1'b0;
        end
        wait_for_done(1'b1, "read to finish");
        foreach (exp[i]) begin
            wait_for_data("read data");
            check_value($sformatf("%s word %0d", name, i), exp[i], rd_data);
            @(posedge clk);
            rd_pop <= 1'b1;
            @(posedge clk);
            rd_pop <= 1'b0;
        end
        repeat (4) @(negedge clk);
        check_value({name, " rd_empty after"}, 32'd1, 32'(rd_empty));
        check_value({name, " done after"}, 32'd1, 32'(done));
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        int              fd;
        int              r;
        int              cnt;
        logic [7:0]      op;
        logic [15:0]     addr;
        logic [31:0]     w;
        logic [31:0]     words[$];
        string           line;
        string           name;

        rst_n     = 1'b0;
        wr_data   = '0;
        wr_valid  = 1'b0;
        cmd       = '0;
        cmd_valid = 1'b0;
        rd_pop    = 1'b0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("reset done", 32'd1, 32'(done));
        check_value("reset cs", 32'd1, 32'(cs));
        check_value("reset sck", 32'd0, 32'(sck));
        check_value("reset mosi", 32'd0, 32'(mosi));
        check_value("reset rd_empty", 32'd1, 32'(rd_empty));
        check_value("reset wr_credit", 32'd0, 32'(wr_credit));

        fd = $fopen("sim/spi_sram_stimulus.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("ERROR: cannot open the stimulus file");
        end else begin
            while (!$feof(fd)) begin
                r = $fscanf(fd, " %c", op);
                if (r != 1) break;
                if (op == "#") begin
                    r = $fgets(line, fd);       // Comment line.
                    continue;
                end
                r = $fscanf(fd, " %h %d", addr, cnt);
                words.delete();
                for (int i = 0; i < cnt; i++) begin
                    r = $fscanf(fd, " %h", w);
                    words.push_back(w);
                end
                name = $sformatf("%c_%04h", op, addr);
                case (op)
                    "W":     run_write(name, addr, words);
                    "R":     run_read(name, addr, words, 1'b0);
                    "B":     run_read(name, addr, words, 1'b1);
                    default: begin
                        errors++;
                        $display("ERROR: unknown command letter in the stimulus file");
                    end
                endcase
            end
            $fclose(fd);
        end

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
hdl/sram_pkg.sv
hdl/word_fifo.sv
hdl/spi_sram_engine.sv
hdl/spi_sram_ctrl.sv
sim/sram_model.sv
sim/spi_sram_properties.sv
sim/tb_spi_sram.sv
